// File: Makefile
SRCS := $(shell grep -v '^+' analog_io_top.f)

.PHONY: run clean

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee /dev/stderr | grep -q "All tests passed!"

obj_dir/Vtb_top: analog_io_top.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_top -f analog_io_top.f

clean:
	rm -rf obj_dir

// File: analog_io_top.f
hw/analog_io_pkg.sv
hw/adc_capture.sv
hw/analog_channel.sv
hw/dac_interleave.sv
hw/sys_regs.sv
hw/analog_io_top.sv
bench/tb_clk.sv
bench/tb_top.sv

// File: bench/tb_clk.sv
//////////////////////////////////////////////////
// testbench clock and reset
//////////////////////////////////////////////////

module tb_clk (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // 8 ns period
  end

  // reset held over the first two rising edges
  initial
  begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// File: bench/tb_top.sv
//////////////////////////////////////////////////
// analog I/O testbench
// bus access, DAC reference checks, loopback ramp, watchdog
//////////////////////////////////////////////////

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SETTLE  = 8;   // cycles before dac_dat_o is trusted
  localparam int N_VEC   = 24;  // constant-input vectors per test
  localparam int N_ROUND = 4;   // register access rounds
  localparam int BUS_CYC = 4;   // worst case per bus access
  localparam int N_RAMP  = 60;  // loopback pairs observed
  localparam int TEST_CYC = 10 + N_ROUND * 10 * BUS_CYC
                          + 2 * N_VEC * (2 * BUS_CYC + SETTLE + 4) + 2 * N_RAMP + 8 * BUS_CYC;
  localparam int TIMEOUT_CYC = 2 * TEST_CYC + 200;

  localparam logic [2:0] HK  = analog_io_pkg::REG_HK;
  localparam logic [2:0] OFS = analog_io_pkg::REG_OFS;

  logic                                                          adc_clk;
  logic                                                          rst_i;
  logic [analog_io_pkg::CHN_NUM-1:0][analog_io_pkg::ADC_WORD_W-1:0] adc_dat_i;
  logic [31:0]                                                   sys_addr_i;
  logic [31:0]                                                   sys_wdata_i;
  logic                                                          sys_wen_i;
  logic                                                          sys_ren_i;
  logic [31:0]                                                   sys_rdata_o;
  logic                                                          sys_ack_o;
  logic [13:0]                                                   dac_dat_o;
  logic                                                          dac_sel_o;
  logic                                                          dac_rst_o;
  logic [7:0]                                                    led_o;
  integer                                                        seed = 32'h578b0c71;

  tb_clk u_clk (
    .clk_o (adc_clk),
    .rst_o (rst_i)
  );

  analog_io_top uut (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_i   (adc_dat_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .dac_dat_o   (dac_dat_o),
    .dac_sel_o   (dac_sel_o),
    .dac_rst_o   (dac_rst_o),
    .led_o       (led_o)
  );

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, act);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  // one strobe, then wait for the ack at the falling edge
  task automatic bus_access(input logic wr, input logic [2:0] region, input logic [19:0] ofs,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    @(posedge adc_clk);
    sys_addr_i  <= {9'd0, region, ofs};
    sys_wdata_i <= wdata;
    sys_wen_i   <= wr;
    sys_ren_i   <= !wr;
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
    n = 0;
    @(negedge adc_clk);
    while (!sys_ack_o && n < BUS_CYC)
    begin
      @(negedge adc_clk);
      n++;
    end
    if (!sys_ack_o)
      abort_run("control bus strobe was never acknowledged");
    rdata = sys_rdata_o;
  endtask

  task automatic write_reg(input logic [2:0] region, input logic [19:0] ofs,
                           input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(1'b1, region, ofs, wdata, unused);
  endtask

  task automatic read_check(input logic [2:0] region, input logic [19:0] ofs,
                            input logic [31:0] exp, input string name);
    logic [31:0] rd;
    bus_access(1'b0, region, ofs, 32'd0, rd);
    assert (rd == exp) else report_mismatch(name, exp, rd);
  endtask

  task automatic drive_adc(input logic [15:0] w0, input logic [15:0] w1);
    @(posedge adc_clk);
    adc_dat_i[0] <= w0;
    adc_dat_i[1] <= w1;
  endtask

  // low phase carries ch0, high phase ch1
  task automatic check_dac(input logic [13:0] exp0, input logic [13:0] exp1);
    repeat (SETTLE) @(negedge adc_clk);
    repeat (2)
    begin
      @(negedge adc_clk);
      if (dac_sel_o)
      begin
        assert (dac_dat_o == exp1) else report_mismatch("dac_dat_o ch1", 32'(exp1), 32'(dac_dat_o));
      end
      else
      begin
        assert (dac_dat_o == exp0) else report_mismatch("dac_dat_o ch0", 32'(exp0), 32'(dac_dat_o));
      end
    end
  endtask

  // one latched pair, low phase then high phase
  task automatic read_pair(output logic [13:0] c0, output logic [13:0] c1);
    @(negedge adc_clk);
    if (dac_sel_o)
      @(negedge adc_clk);
    c0 = dac_dat_o;
    @(negedge adc_clk);
    c1 = dac_dat_o;
  endtask

  // adc word -> two's compl, add, clamp, back to offset binary
  function automatic logic [13:0] ref_code(input logic [15:0] word, input logic signed [13:0] ofs);
    logic signed [13:0] smp;
    int                 sum;
    smp = {word[15], ~word[14:2]};
    sum = int'(smp) + int'(ofs);
    if (sum > int'(analog_io_pkg::SAT_MAX))
      sum = int'(analog_io_pkg::SAT_MAX);
    else if (sum < int'(analog_io_pkg::SAT_MIN))
      sum = int'(analog_io_pkg::SAT_MIN);
    return {sum[13], ~sum[12:0]};
  endfunction

  function automatic int code_val(input logic [13:0] code);
    return int'($signed({code[13], ~code[12:0]}));  // offset binary back to signed
  endfunction

  //////////////////////////////////////////////////
  // protocol and select checks

  a_ack_next : assert property (@(posedge adc_clk) disable iff (rst_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o)
    else report_mismatch("sys_ack_o", 32'd1, 32'(sys_ack_o));

  a_ack_once : assert property (@(posedge adc_clk) disable iff (rst_i)
    !(sys_wen_i || sys_ren_i) |=> !sys_ack_o)
    else report_mismatch("sys_ack_o", 32'd0, 32'(sys_ack_o));

  a_sel_alt : assert property (@(posedge adc_clk) disable iff (rst_i)
    !dac_rst_o |=> (dac_sel_o != $past(dac_sel_o)))
    else report_mismatch("dac_sel_o", 32'(!dac_sel_o), 32'(dac_sel_o));

  initial
  begin
    logic [31:0]        rnd;
    logic [15:0]        w0;
    logic [15:0]        w1;
    logic signed [13:0] o0;
    logic signed [13:0] o1;
    logic [13:0]        c0;
    logic [13:0]        c1;
    logic [2:0]         region;
    int                 prev0;
    int                 prev1;
    adc_dat_i   = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;

    // reset values, inside reset then one cycle after
    @(posedge adc_clk);
    @(negedge adc_clk);
    assert (dac_rst_o) else report_mismatch("dac_rst_o", 32'd1, 32'(dac_rst_o));
    assert (!dac_sel_o) else report_mismatch("dac_sel_o", 32'd0, 32'(dac_sel_o));
    assert (led_o == 8'h00) else report_mismatch("led_o", 32'd0, 32'(led_o));
    assert (!sys_ack_o) else report_mismatch("sys_ack_o", 32'd0, 32'(sys_ack_o));
    assert (dac_dat_o == 14'h1FFF) else report_mismatch("dac_dat_o", 32'h1FFF, 32'(dac_dat_o));
    wait (!rst_i);
    @(negedge adc_clk);
    assert (dac_rst_o) else report_mismatch("dac_rst_o", 32'd1, 32'(dac_rst_o));
    @(negedge adc_clk);
    assert (!dac_rst_o) else report_mismatch("dac_rst_o", 32'd0, 32'(dac_rst_o));

    //////////////////////////////////////////////////
    // register access

    for (int r = 0; r < N_ROUND; r++)
    begin
      read_check(HK, analog_io_pkg::HK_ID_OFS, analog_io_pkg::BOARD_ID, "sys_rdata_o id");
      rnd = $random(seed);
      write_reg(HK, analog_io_pkg::HK_CTRL_OFS, rnd);
      read_check(HK, analog_io_pkg::HK_CTRL_OFS, {31'd0, rnd[0]}, "sys_rdata_o ctrl");
      rnd = $random(seed);
      write_reg(HK, analog_io_pkg::HK_LED_OFS, rnd);
      read_check(HK, analog_io_pkg::HK_LED_OFS, {24'd0, rnd[7:0]}, "sys_rdata_o led");
      assert (led_o == rnd[7:0]) else report_mismatch("led_o", 32'(rnd[7:0]), 32'(led_o));
      rnd = $random(seed);
      write_reg(OFS, analog_io_pkg::OFS_CH0_OFS, rnd);
      read_check(OFS, analog_io_pkg::OFS_CH0_OFS, {18'd0, rnd[13:0]}, "sys_rdata_o ofs0");
      rnd = $random(seed);
      write_reg(OFS, analog_io_pkg::OFS_CH1_OFS, rnd);
      read_check(OFS, analog_io_pkg::OFS_CH1_OFS, {18'd0, rnd[13:0]}, "sys_rdata_o ofs1");
      rnd = $random(seed);
      region = (rnd[2:0] < 3'd2) ? rnd[2:0] + 3'd2 : rnd[2:0];  // regions 2..7 only
      read_check(region, {rnd[19:2], 2'b00}, 32'd0, "sys_rdata_o unused");
    end

    // zero offsets, code is just the top 14 ADC bits
    write_reg(HK, analog_io_pkg::HK_CTRL_OFS, 32'd0);
    write_reg(OFS, analog_io_pkg::OFS_CH0_OFS, 32'd0);
    write_reg(OFS, analog_io_pkg::OFS_CH1_OFS, 32'd0);
    for (int i = 0; i < N_VEC; i++)
    begin
      rnd = $random(seed);
      drive_adc(rnd[15:0], rnd[31:16]);
      check_dac(rnd[15:2], rnd[31:18]);
    end

    //////////////////////////////////////////////////
    // random offsets, first two vectors clip

    for (int i = 0; i < N_VEC; i++)
    begin
      rnd = $random(seed);
      w0 = rnd[15:0];
      w1 = rnd[31:16];
      rnd = $random(seed);
      o0 = rnd[13:0];
      o1 = rnd[29:16];
      if (i == 0)
      begin
        w0 = 16'h0000;  // +8191, over the top
        o0 = 14'sd100;
        w1 = 16'hFFFF;  // -8192, under the bottom
        o1 = -14'sd100;
      end
      else if (i == 1)
      begin
        w0 = 16'hFFFF;
        o0 = -14'sd50;
        w1 = 16'h0003;  // reserved bits set
        o1 = 14'sd50;
      end
      write_reg(OFS, analog_io_pkg::OFS_CH0_OFS, 32'(o0));
      write_reg(OFS, analog_io_pkg::OFS_CH1_OFS, 32'(o1));
      drive_adc(w0, w1);
      check_dac(ref_code(w0, o0), ref_code(w1, o1));
    end

    // loopback ramp, ch0 up and ch1 down into the limits
    rnd = $random(seed);
    o0 = 14'(200 + int'(rnd[9:0]));
    o1 = 14'(-200 - int'(rnd[25:16]));
    write_reg(OFS, analog_io_pkg::OFS_CH0_OFS, 32'(o0));
    write_reg(OFS, analog_io_pkg::OFS_CH1_OFS, 32'(o1));
    repeat (SETTLE) @(negedge adc_clk);
    read_pair(c0, c1);
    prev0 = code_val(c0);
    prev1 = code_val(c1);
    write_reg(HK, analog_io_pkg::HK_CTRL_OFS, 32'd1);
    repeat (N_RAMP)
    begin
      read_pair(c0, c1);
      assert (code_val(c0) >= prev0) else report_mismatch("dac_dat_o ch0 ramp", prev0, code_val(c0));
      assert (code_val(c1) <= prev1) else report_mismatch("dac_dat_o ch1 ramp", prev1, code_val(c1));
      prev0 = code_val(c0);
      prev1 = code_val(c1);
    end
    assert (c0 == 14'h0000) else report_mismatch("dac_dat_o ch0 end", 32'h0000, 32'(c0));
    assert (c1 == 14'h3FFF) else report_mismatch("dac_dat_o ch1 end", 32'h3FFF, 32'(c1));
    write_reg(HK, analog_io_pkg::HK_CTRL_OFS, 32'd0);

    $display("All tests passed!");
    $finish;
  end

  // watchdog, twice the summed test length
  initial
  begin
    repeat (TIMEOUT_CYC) @(posedge adc_clk);
    abort_run("timeout: tests did not finish in the expected number of cycles");
  end

endmodule

// File: hw/adc_capture.sv
//////////////////////////////////////////////////
// ADC capture
// input registers, negative-slope offset binary to two's complement
//////////////////////////////////////////////////

module adc_capture (
  input  logic                                   adc_clk,
  input  logic                                   rst_i,
  input  logic [analog_io_pkg::CHN_NUM-1:0][analog_io_pkg::ADC_WORD_W-1:0] adc_dat_i,
  output logic signed [analog_io_pkg::DAT_W-1:0] sample_o [analog_io_pkg::CHN_NUM]
);

  localparam int unsigned MSB = analog_io_pkg::ADC_WORD_W - 1;  // sign position
  localparam int unsigned LSB = analog_io_pkg::ADC_WORD_W - analog_io_pkg::DAT_W;

  // two reserved bits dropped, sign kept, magnitude bits flipped
  always_ff @(posedge adc_clk)
  begin
    for (int ch = 0; ch < analog_io_pkg::CHN_NUM; ch++)
    begin
      if (rst_i)
        sample_o[ch] <= '0;  // mid scale
      else
        sample_o[ch] <= {adc_dat_i[ch][MSB], ~adc_dat_i[ch][MSB-1:LSB]};
    end
  end

endmodule

// File: hw/analog_channel.sv
//////////////////////////////////////////////////
// analog channel stage
// loopback select, DC offset add and 14-bit saturation
//////////////////////////////////////////////////

module analog_channel (
  input  logic                                   adc_clk,
  input  logic                                   rst_i,
  input  logic signed [analog_io_pkg::DAT_W-1:0] sample_i,       // from ADC
  input  logic signed [analog_io_pkg::DAT_W-1:0] offset_i,       // DC offset reg
  input  logic                                   digital_loop_i,
  output logic signed [analog_io_pkg::DAT_W-1:0] result_o
);

  localparam int unsigned SUM_W = analog_io_pkg::DAT_W + 1;  // one guard bit

  logic signed [analog_io_pkg::DAT_W-1:0] dat_sel;  // ADC or own feedback
  logic signed [SUM_W-1:0]                dat_sum;
  logic signed [analog_io_pkg::DAT_W-1:0] dat_sat;

  // loopback takes our own last DAC value
  assign dat_sel = digital_loop_i ? result_o : sample_i;

  // both operands sign extended by one bit
  assign dat_sum = SUM_W'(dat_sel) + SUM_W'(offset_i);

  // top two bits differ -> overflow, pick limit by sum sign
  always_comb
  begin
    if (dat_sum[SUM_W-1:SUM_W-2] == 2'b01)
      dat_sat = analog_io_pkg::SAT_MAX;
    else if (dat_sum[SUM_W-1:SUM_W-2] == 2'b10)
      dat_sat = analog_io_pkg::SAT_MIN;
    else
      dat_sat = dat_sum[analog_io_pkg::DAT_W-1:0];
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      result_o <= '0;
    else
      result_o <= dat_sat;
  end

  // feedback loop starts from zero
  a_zero_after_reset : assert property (
    @(posedge adc_clk)
    rst_i |=> (result_o == '0)
  );

endmodule

// File: hw/analog_io_pkg.sv
//////////////////////////////////////////////////
// analog I/O constants
// widths, bus map and limits shared by the data path and register block
//////////////////////////////////////////////////

package analog_io_pkg;

  // data path
  localparam int unsigned CHN_NUM    = 2;   // interleaved analog channels
  localparam int unsigned ADC_WORD_W = 16;  // raw ADC word, 2 LSBs reserved
  localparam int unsigned DAT_W      = 14;  // sample and DAC code width

  // control bus
  localparam int unsigned SYS_AW = 32;
  localparam int unsigned SYS_DW = 32;

  // regions, taken from address bits 22:20
  localparam logic [2:0] REG_HK  = 3'd0;  // housekeeping
  localparam logic [2:0] REG_OFS = 3'd1;  // channel offsets

  // byte offsets inside housekeeping
  localparam logic [19:0] HK_ID_OFS   = 20'h00000;
  localparam logic [19:0] HK_CTRL_OFS = 20'h00004;  // bit 0 digital loopback
  localparam logic [19:0] HK_LED_OFS  = 20'h00008;

  // byte offsets inside the offset region
  localparam logic [19:0] OFS_CH0_OFS = 20'h00000;
  localparam logic [19:0] OFS_CH1_OFS = 20'h00004;

  // read-only board identification
  localparam logic [SYS_DW-1:0] BOARD_ID = 32'hA10C_0002;

  // 14-bit signed saturation limits
  localparam logic signed [DAT_W-1:0] SAT_MAX = 8191;
  localparam logic signed [DAT_W-1:0] SAT_MIN = -8192;

endpackage

// File: hw/analog_io_top.sv
//////////////////////////////////////////////////
// analog I/O top level
// ADC capture, per-channel offset stage, DAC interleaver and control registers
//////////////////////////////////////////////////

module analog_io_top (
  input  logic                                    adc_clk,
  input  logic                                    rst_i,
  // ADC sample bus, one word per channel
  input  logic [analog_io_pkg::CHN_NUM-1:0][analog_io_pkg::ADC_WORD_W-1:0] adc_dat_i,
  // control bus
  input  logic [analog_io_pkg::SYS_AW-1:0]        sys_addr_i,
  input  logic [analog_io_pkg::SYS_DW-1:0]        sys_wdata_i,
  input  logic                                    sys_wen_i,
  input  logic                                    sys_ren_i,
  output logic [analog_io_pkg::SYS_DW-1:0]        sys_rdata_o,
  output logic                                    sys_ack_o,
  // DAC, both channels on one bus
  output logic [analog_io_pkg::DAT_W-1:0]         dac_dat_o,
  output logic                                    dac_sel_o,  // 0 ch0, 1 ch1
  output logic                                    dac_rst_o,
  output logic [7:0]                              led_o
);

  //////////////////////////////////////////////////
  // internal wires

  logic                                      digital_loop;  // loopback enable
  logic signed [analog_io_pkg::DAT_W-1:0]    offset [analog_io_pkg::CHN_NUM];
  logic signed [analog_io_pkg::DAT_W-1:0]    sample [analog_io_pkg::CHN_NUM];  // two's compl
  logic signed [analog_io_pkg::DAT_W-1:0]    result [analog_io_pkg::CHN_NUM];  // saturated

  // register block, all eight bus regions
  sys_regs u_sys_regs (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (sys_wen_i),
    .sys_ren_i      (sys_ren_i),
    .sys_rdata_o    (sys_rdata_o),
    .sys_ack_o      (sys_ack_o),
    .digital_loop_o (digital_loop),
    .led_o          (led_o),
    .offset_o       (offset)
  );

  // ADC input registers
  adc_capture u_adc_capture (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .adc_dat_i (adc_dat_i),
    .sample_o  (sample)
  );

  //////////////////////////////////////////////////
  // one offset and saturate stage per channel

  for (genvar ch = 0; ch < analog_io_pkg::CHN_NUM; ch++)
  begin : g_chan
    analog_channel u_channel (
      .adc_clk        (adc_clk),
      .rst_i          (rst_i),
      .sample_i       (sample[ch]),
      .offset_i       (offset[ch]),
      .digital_loop_i (digital_loop),  // shared by both channels
      .result_o       (result[ch])
    );
  end

  // back to offset binary, time multiplexed
  dac_interleave u_dac_interleave (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .result_i  (result),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule

// File: hw/dac_interleave.sv
//////////////////////////////////////////////////
// DAC interleaver
// offset binary codes for both channels on one bus, alternating select
//////////////////////////////////////////////////

module dac_interleave (
  input  logic                                   adc_clk,
  input  logic                                   rst_i,
  input  logic signed [analog_io_pkg::DAT_W-1:0] result_i [analog_io_pkg::CHN_NUM],
  output logic [analog_io_pkg::DAT_W-1:0]        dac_dat_o,
  output logic                                   dac_sel_o,
  output logic                                   dac_rst_o
);

  localparam int unsigned MSB = analog_io_pkg::DAT_W - 1;

  logic [analog_io_pkg::DAT_W-1:0] dac_code [analog_io_pkg::CHN_NUM];  // latched pair

  // DAC reset, held one extra cycle after release
  always_ff @(posedge adc_clk)
  begin
    dac_rst_o <= rst_i;
  end

  // select toggles every cycle once the DAC is out of reset
  always_ff @(posedge adc_clk)
  begin
    if (rst_i || dac_rst_o)
      dac_sel_o <= 1'b0;
    else
      dac_sel_o <= ~dac_sel_o;
  end

  // pair captured on the high to low edge of sel
  always_ff @(posedge adc_clk)
  begin
    for (int ch = 0; ch < analog_io_pkg::CHN_NUM; ch++)
    begin
      if (rst_i)
        dac_code[ch] <= {1'b0, {MSB{1'b1}}};  // code for zero
      else if (!dac_rst_o && dac_sel_o)
        dac_code[ch] <= {result_i[ch][MSB], ~result_i[ch][MSB-1:0]};
    end
  end

  assign dac_dat_o = dac_sel_o ? dac_code[1] : dac_code[0];  // low ch0, high ch1

  // one channel per cycle, no stall outside reset
  a_sel_toggles : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    !dac_rst_o |=> (dac_sel_o != $past(dac_sel_o))
  );

endmodule

// File: hw/sys_regs.sv
//////////////////////////////////////////////////
// control bus register block
// region decode, housekeeping and offset registers, read mux, acknowledge
//////////////////////////////////////////////////

module sys_regs (
  input  logic                                   adc_clk,
  input  logic                                   rst_i,
  // control bus
  input  logic [analog_io_pkg::SYS_AW-1:0]       sys_addr_i,
  input  logic [analog_io_pkg::SYS_DW-1:0]       sys_wdata_i,
  input  logic                                   sys_wen_i,
  input  logic                                   sys_ren_i,
  output logic [analog_io_pkg::SYS_DW-1:0]       sys_rdata_o,
  output logic                                   sys_ack_o,
  // configuration outputs
  output logic                                   digital_loop_o,
  output logic [7:0]                             led_o,
  output logic signed [analog_io_pkg::DAT_W-1:0] offset_o [analog_io_pkg::CHN_NUM]
);

  //////////////////////////////////////////////////
  // address split

  logic [2:0]                        region;     // addr 22:20, eight regions
  logic [19:0]                       reg_ofs;    // byte offset in region
  logic [analog_io_pkg::SYS_DW-1:0]  rdata_mux;  // combinational read value

  assign region  = sys_addr_i[22:20];
  assign reg_ofs = sys_addr_i[19:0];

  //////////////////////////////////////////////////
  // register writes
  // write lands on the strobe edge, same edge that raises ack

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      for (int ch = 0; ch < analog_io_pkg::CHN_NUM; ch++)
      begin
        offset_o[ch] <= '0;  // no DC shift out of reset
      end
    end
    else if (sys_wen_i)
    begin
      if (region == analog_io_pkg::REG_HK)
      begin
        case (reg_ofs)
          analog_io_pkg::HK_CTRL_OFS: digital_loop_o <= sys_wdata_i[0];
          analog_io_pkg::HK_LED_OFS:  led_o          <= sys_wdata_i[7:0];
          default: ;  // ID is read only
        endcase
      end
      else if (region == analog_io_pkg::REG_OFS)
      begin
        case (reg_ofs)
          analog_io_pkg::OFS_CH0_OFS: offset_o[0] <= sys_wdata_i[analog_io_pkg::DAT_W-1:0];
          analog_io_pkg::OFS_CH1_OFS: offset_o[1] <= sys_wdata_i[analog_io_pkg::DAT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // read multiplexer
  // unmapped offsets and regions 2..7 read zero

  always_comb
  begin
    rdata_mux = '0;
    if (region == analog_io_pkg::REG_HK)
    begin
      case (reg_ofs)
        analog_io_pkg::HK_ID_OFS:   rdata_mux = analog_io_pkg::BOARD_ID;
        analog_io_pkg::HK_CTRL_OFS: rdata_mux[0]   = digital_loop_o;
        analog_io_pkg::HK_LED_OFS:  rdata_mux[7:0] = led_o;
        default: ;
      endcase
    end
    else if (region == analog_io_pkg::REG_OFS)
    begin
      // offsets come back zero extended, raw 14-bit field
      case (reg_ofs)
        analog_io_pkg::OFS_CH0_OFS: rdata_mux[analog_io_pkg::DAT_W-1:0] = offset_o[0];
        analog_io_pkg::OFS_CH1_OFS: rdata_mux[analog_io_pkg::DAT_W-1:0] = offset_o[1];
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // acknowledge and read data, one cycle after strobe

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      sys_ack_o <= 1'b0;
    else
      sys_ack_o <= sys_wen_i | sys_ren_i;  // every region answers
  end

  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
      sys_rdata_o <= rdata_mux;  // only meaningful with ack
  end

  // ack never appears without a strobe one cycle earlier
  a_ack_after_strobe : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i)
  );

  // master waits for the ack before the next strobe
  a_no_strobe_pending : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    (sys_wen_i || sys_ren_i) |=> !(sys_wen_i || sys_ren_i)
  );

endmodule
